//--- mshr_pkg.sv
package mshr_pkg;

    // byte address
    typedef logic [31:0] addr_t;

    // 16-byte lines
    localparam int line_offset_bits = 4;

    typedef logic [31-line_offset_bits:0] line_t;

    // cache op code passed through to L2 untouched
    typedef enum logic [2:0] {
        op_load     = 3'd0,
        op_store    = 3'd1,  // the only store
        op_prefetch = 3'd2
    } op_t;

    function automatic line_t line_of(input addr_t addr);
        return addr[31:line_offset_bits];
    endfunction

    // zero or multi-hot input gives index 0
    function automatic logic [3:0] onehot_to_index(input logic [15:0] vec);
        logic [3:0]  idx;
        int unsigned ones;
        idx = '0;
        ones = 0;
        for (int i = 0; i < 16; i++) begin
            if (vec[i]) begin
                idx = 4'(i);
                ones++;
            end
        end
        if (ones != 1) begin
            idx = '0;
        end
        return idx;
    endfunction

endpackage

//--- miss_queue.sv
module miss_queue #(
    parameter int q_length = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr,
    input  logic [$clog2(q_length)-1:0]  wr_ptr,
    input  mshr_pkg::line_t              wr_line,
    input  mshr_pkg::op_t                wr_op,
    input  logic [q_length-1:0]          mark_vector,
    input  mshr_pkg::line_t              cmp_line_a,
    input  mshr_pkg::line_t              cmp_line_b,
    input  logic [$clog2(q_length)-1:0]  rd_ptr,
    output logic [q_length-1:0]          match_a,
    output logic [q_length-1:0]          match_b,
    output logic                         full,
    output mshr_pkg::line_t              rd_line,
    output mshr_pkg::op_t                rd_op
);

    localparam int ptr_w = $clog2(q_length);
    localparam int cnt_w = ptr_w + 1;

    logic [q_length-1:0] valid;
    logic [q_length-1:0] done;
    logic [q_length-1:0] valid_next;
    logic [q_length-1:0] done_next;
    logic [ptr_w-1:0]    head;
    logic [cnt_w-1:0]    count;
    logic                retire;

    mshr_pkg::line_t line_mem [q_length];
    mshr_pkg::op_t   op_mem   [q_length];

    // only live entries that still wait for their fill take part
    always_comb begin
        for (int i = 0; i < q_length; i++) begin
            match_a[i] = valid[i] && !done[i] && (line_mem[i] == cmp_line_a);
            match_b[i] = valid[i] && !done[i] && (line_mem[i] == cmp_line_b);
        end
    end

    assign retire = valid[head] && done[head];  // oldest first while younger done ones wait
    assign full = (count == cnt_w'(q_length));

    assign rd_line = line_mem[rd_ptr];
    assign rd_op = op_mem[rd_ptr];

    always_comb begin
        valid_next = valid;
        done_next = done | (mark_vector & valid);
        if (retire) begin
            valid_next[head] = 1'b0;
            done_next[head] = 1'b0;
        end
        // writer never targets a live slot since intake drops when full
        if (wr) begin
            valid_next[wr_ptr] = 1'b1;
            done_next[wr_ptr] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            done <= '0;
        end else begin
            valid <= valid_next;
            done <= done_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
        end else if (retire) begin
            head <= head + 1'b1;  // wraps on its own at a power of two
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({wr, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // line and op per slot
    always_ff @(posedge clk) begin
        if (wr) begin
            line_mem[wr_ptr] <= wr_line;
            op_mem[wr_ptr] <= wr_op;
        end
    end

endmodule

//--- mshr.sv
module mshr #(
    parameter int q_length = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc,
    input  mshr_pkg::line_t              alloc_line,
    input  mshr_pkg::op_t                alloc_op,
    input  mshr_pkg::line_t              lookup_line,
    input  logic                         l2_resp_valid,
    input  mshr_pkg::addr_t              l2_resp_addr,
    input  logic [$clog2(q_length)-1:0]  rd_ptr,
    output logic                         hit,
    output logic [$clog2(q_length)-1:0]  hit_ptr,
    output logic [$clog2(q_length)-1:0]  alloc_ptr,
    output logic                         fill_done,
    output logic [$clog2(q_length)-1:0]  fill_ptr,
    output logic                         full,
    output mshr_pkg::line_t              rd_line,
    output mshr_pkg::op_t                rd_op
);

    localparam int ptr_w = $clog2(q_length);

    logic [ptr_w-1:0]    wr_ptr;
    logic [q_length-1:0] hit_vector;
    logic [q_length-1:0] resp_vector;
    logic [q_length-1:0] fill_vector;
    mshr_pkg::line_t     resp_line;

    assign resp_line = mshr_pkg::line_of(l2_resp_addr);

    miss_queue #(
        .q_length (q_length)
    ) queue0 (
        .clk         (clk),
        .rst         (rst),
        .wr          (alloc),
        .wr_ptr      (wr_ptr),
        .wr_line     (alloc_line),
        .wr_op       (alloc_op),
        .mark_vector (fill_vector),
        .cmp_line_a  (lookup_line),
        .cmp_line_b  (resp_line),
        .rd_ptr      (rd_ptr),
        .match_a     (hit_vector),
        .match_b     (resp_vector),
        .full        (full),
        .rd_line     (rd_line),
        .rd_op       (rd_op)
    );

    // a line is tracked by at most one pending entry
    assign hit = |hit_vector;
    assign hit_ptr = ptr_w'(mshr_pkg::onehot_to_index(16'(hit_vector)));

    assign fill_vector = l2_resp_valid ? resp_vector : '0;  // unmatched response drops out
    assign fill_done = |fill_vector;
    assign fill_ptr = ptr_w'(mshr_pkg::onehot_to_index(16'(fill_vector)));

    assign alloc_ptr = wr_ptr;  // slot taken by this alloc

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (alloc) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

endmodule

//--- miss_intake.sv
module miss_intake #(
    parameter int q_length = 8
) (
    input  logic                         miss_valid,
    input  mshr_pkg::op_t                miss_op,
    input  mshr_pkg::addr_t              miss_addr,
    input  logic                         hit,
    input  logic [$clog2(q_length)-1:0]  hit_ptr,
    input  logic                         full,
    output mshr_pkg::line_t              lookup_line,
    output logic                         alloc,
    output mshr_pkg::line_t              alloc_line,
    output mshr_pkg::op_t                alloc_op,
    output logic                         merge,
    output logic [$clog2(q_length)-1:0]  merge_ptr,
    output logic                         drop
);

    mshr_pkg::line_t miss_line;

    assign miss_line = mshr_pkg::line_of(miss_addr);
    assign lookup_line = miss_line;

    // exactly one of the three per valid miss
    always_comb begin
        merge = 1'b0;
        alloc = 1'b0;
        drop = 1'b0;
        if (miss_valid) begin
            if (hit) begin
                merge = 1'b1;  // wins even when full
            end else if (!full) begin
                alloc = 1'b1;
            end else begin
                drop = 1'b1;
            end
        end
    end

    // secondary miss leaves the entry's op as it was
    assign merge_ptr = hit_ptr;

    assign alloc_line = miss_line;
    assign alloc_op = miss_op;

endmodule

//--- l2_request_issue.sv
module l2_request_issue #(
    parameter int q_length = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc,
    input  logic                         l2_stall,
    input  mshr_pkg::line_t              rd_line,
    input  mshr_pkg::op_t                rd_op,
    output logic [$clog2(q_length)-1:0]  rd_ptr,
    output logic                         l2_req_valid,
    output mshr_pkg::line_t              l2_req_line,
    output mshr_pkg::op_t                l2_req_op,
    output logic [$clog2(q_length)-1:0]  l2_req_ptr
);

    localparam int ptr_w = $clog2(q_length);
    localparam int cnt_w = ptr_w + 1;

    logic [ptr_w-1:0] issue_ptr;
    logic [cnt_w-1:0] pending;
    logic             issue;

    // pending never passes q_length as entries can't outnumber slots
    assign issue = (pending != '0) && !l2_stall;
    assign rd_ptr = issue_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            case ({alloc, issue})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_ptr <= '0;
            l2_req_valid <= 1'b0;
        end else begin
            l2_req_valid <= issue;
            if (issue) begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

    // a fill needs a request first so the slot is still live here
    always_ff @(posedge clk) begin
        if (issue) begin
            l2_req_line <= rd_line;
            l2_req_op <= rd_op;
            l2_req_ptr <= issue_ptr;
        end
    end

endmodule

//--- mshr_top.sv
module mshr_top #(
    parameter int q_length = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         miss_valid,
    input  mshr_pkg::op_t                miss_op,
    input  mshr_pkg::addr_t              miss_addr,
    input  logic                         l2_stall,
    input  logic                         l2_resp_valid,
    input  mshr_pkg::addr_t              l2_resp_addr,
    output logic                         mshr_full,
    output logic                         miss_alloc,
    output logic [$clog2(q_length)-1:0]  miss_alloc_ptr,
    output logic                         miss_merge,
    output logic [$clog2(q_length)-1:0]  miss_merge_ptr,
    output logic                         miss_drop,
    output logic                         l2_req_valid,
    output mshr_pkg::line_t              l2_req_line,
    output mshr_pkg::op_t                l2_req_op,
    output logic [$clog2(q_length)-1:0]  l2_req_ptr,
    output logic                         fill_done,
    output logic [$clog2(q_length)-1:0]  fill_ptr
);

    localparam int ptr_w = $clog2(q_length);

    mshr_pkg::line_t  lookup_line;
    mshr_pkg::line_t  alloc_line;
    mshr_pkg::op_t    alloc_op;
    logic             hit;
    logic [ptr_w-1:0] hit_ptr;
    logic [ptr_w-1:0] rd_ptr;
    mshr_pkg::line_t  rd_line;
    mshr_pkg::op_t    rd_op;

    miss_intake #(
        .q_length (q_length)
    ) intake0 (
        .miss_valid  (miss_valid),
        .miss_op     (miss_op),
        .miss_addr   (miss_addr),
        .hit         (hit),
        .hit_ptr     (hit_ptr),
        .full        (mshr_full),
        .lookup_line (lookup_line),
        .alloc       (miss_alloc),
        .alloc_line  (alloc_line),
        .alloc_op    (alloc_op),
        .merge       (miss_merge),
        .merge_ptr   (miss_merge_ptr),
        .drop        (miss_drop)
    );

    mshr #(
        .q_length (q_length)
    ) mshr0 (
        .clk           (clk),
        .rst           (rst),
        .alloc         (miss_alloc),
        .alloc_line    (alloc_line),
        .alloc_op      (alloc_op),
        .lookup_line   (lookup_line),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp_addr  (l2_resp_addr),
        .rd_ptr        (rd_ptr),
        .hit           (hit),
        .hit_ptr       (hit_ptr),
        .alloc_ptr     (miss_alloc_ptr),
        .fill_done     (fill_done),
        .fill_ptr      (fill_ptr),
        .full          (mshr_full),
        .rd_line       (rd_line),
        .rd_op         (rd_op)
    );

    l2_request_issue #(
        .q_length (q_length)
    ) issue0 (
        .clk          (clk),
        .rst          (rst),
        .alloc        (miss_alloc),
        .l2_stall     (l2_stall),
        .rd_line      (rd_line),
        .rd_op        (rd_op),
        .rd_ptr       (rd_ptr),
        .l2_req_valid (l2_req_valid),
        .l2_req_line  (l2_req_line),
        .l2_req_op    (l2_req_op),
        .l2_req_ptr   (l2_req_ptr)
    );

endmodule

//--- tb_mshr.sv
module tb_mshr;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int q_length = 8;
    localparam int ptr_w = $clog2(q_length);
    localparam int directed_cycles = 150;
    localparam int stall_cycles = 80;
    localparam int random_cycles = 400;
    localparam int total_cycles = directed_cycles + stall_cycles + random_cycles;

    logic            clk;
    logic            rst;
    logic            miss_valid;
    mshr_pkg::op_t   miss_op;
    mshr_pkg::addr_t miss_addr;
    logic            l2_stall;
    logic            l2_resp_valid;
    mshr_pkg::addr_t l2_resp_addr;
    logic            mshr_full;
    logic            miss_alloc;
    logic [ptr_w-1:0] miss_alloc_ptr;
    logic            miss_merge;
    logic [ptr_w-1:0] miss_merge_ptr;
    logic            miss_drop;
    logic            l2_req_valid;
    mshr_pkg::line_t l2_req_line;
    mshr_pkg::op_t   l2_req_op;
    logic [ptr_w-1:0] l2_req_ptr;
    logic            fill_done;
    logic [ptr_w-1:0] fill_ptr;

    // reference model of the entries and the request stream
    bit              valid_m     [q_length];
    bit              done_m      [q_length];
    bit              requested_m [q_length];
    mshr_pkg::line_t line_m      [q_length];
    mshr_pkg::op_t   op_m        [q_length];
    int              head_m;
    int              wr_m;
    int              count_m;
    int              pend_m;
    bit              req_valid_m;
    int              req_q [$];  // allocated, request not seen yet

    string test_name;
    int    fresh_line;
    int    n_alloc, n_merge, n_drop, n_fill, n_unknown, n_stalled, n_full_merge;

    mshr_top #(
        .q_length (q_length)
    ) dut0 (
        .clk            (clk),
        .rst            (rst),
        .miss_valid     (miss_valid),
        .miss_op        (miss_op),
        .miss_addr      (miss_addr),
        .l2_stall       (l2_stall),
        .l2_resp_valid  (l2_resp_valid),
        .l2_resp_addr   (l2_resp_addr),
        .mshr_full      (mshr_full),
        .miss_alloc     (miss_alloc),
        .miss_alloc_ptr (miss_alloc_ptr),
        .miss_merge     (miss_merge),
        .miss_merge_ptr (miss_merge_ptr),
        .miss_drop      (miss_drop),
        .l2_req_valid   (l2_req_valid),
        .l2_req_line    (l2_req_line),
        .l2_req_op      (l2_req_op),
        .l2_req_ptr     (l2_req_ptr),
        .fill_done      (fill_done),
        .fill_ptr       (fill_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(20 * total_cycles * 10);
        $display("Timeout: the run did not reach its end in time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (exp === act) else begin
            $display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("Finished with errors");
            $fatal(1, "first error");
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            $display("Finished with errors");
            $fatal(1, "first error");
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < q_length; i++) begin
            valid_m[i] = 1'b0;
            done_m[i] = 1'b0;
            requested_m[i] = 1'b0;
        end
        head_m = 0;
        wr_m = 0;
        count_m = 0;
        pend_m = 0;
        req_valid_m = 1'b0;
        req_q.delete();
    endtask

    // compares this cycle's outputs, then applies the coming edge to the model
    task automatic check_and_step();
        mshr_pkg::line_t miss_line;
        mshr_pkg::line_t resp_line;
        bit hit, fill, full, alloc, retire, issue;
        int hit_i, fill_i, p;
        hit = 1'b0;
        fill = 1'b0;
        hit_i = 0;
        fill_i = 0;
        miss_line = miss_addr[31:4];
        resp_line = l2_resp_addr[31:4];
        for (int i = 0; i < q_length; i++) begin
            if (valid_m[i] && !done_m[i] && line_m[i] == miss_line) begin
                hit = 1'b1;
                hit_i = i;
            end
            if (valid_m[i] && !done_m[i] && line_m[i] == resp_line) begin
                fill = 1'b1;
                fill_i = i;
            end
        end
        fill = fill && l2_resp_valid;
        full = (count_m == q_length);
        alloc = miss_valid && !hit && !full;
        check_bit("mshr_full", full, mshr_full);
        check_bit("miss_alloc", alloc, miss_alloc);
        check_bit("miss_merge", miss_valid && hit, miss_merge);
        check_bit("miss_drop", miss_valid && !hit && full, miss_drop);
        if (alloc) check_val("miss_alloc_ptr", wr_m, 32'(miss_alloc_ptr));
        if (miss_valid && hit) check_val("miss_merge_ptr", hit_i, 32'(miss_merge_ptr));
        check_bit("fill_done", fill, fill_done);
        if (fill) check_val("fill_ptr", fill_i, 32'(fill_ptr));
        check_bit("l2_req_valid", req_valid_m, l2_req_valid);
        if (l2_req_valid && req_q.size() > 0) begin
            p = req_q.pop_front();
            check_val("l2_req_ptr", p, 32'(l2_req_ptr));
            check_val("l2_req_line", 32'(line_m[p]), 32'(l2_req_line));
            check_val("l2_req_op", 32'(op_m[p]), 32'(l2_req_op));
            requested_m[p] = 1'b1;
        end
        n_alloc += int'(alloc);
        n_merge += int'(miss_valid && hit);
        n_drop += int'(miss_valid && !hit && full);
        n_full_merge += int'(miss_valid && hit && full);
        n_fill += int'(fill);
        n_unknown += int'(l2_resp_valid && !fill);
        n_stalled += int'(l2_stall && pend_m > 0);

        retire = valid_m[head_m] && done_m[head_m];  // oldest only
        issue = (pend_m > 0) && !l2_stall;
        req_valid_m = issue;
        if (retire) begin
            valid_m[head_m] = 1'b0;
            done_m[head_m] = 1'b0;
            head_m = (head_m + 1) % q_length;
            count_m--;
        end
        if (fill) done_m[fill_i] = 1'b1;
        if (alloc) begin
            valid_m[wr_m] = 1'b1;
            done_m[wr_m] = 1'b0;
            requested_m[wr_m] = 1'b0;
            line_m[wr_m] = miss_line;
            op_m[wr_m] = miss_op;
            req_q.push_back(wr_m);
            wr_m = (wr_m + 1) % q_length;
            count_m++;
        end
        pend_m = pend_m + int'(alloc) - int'(issue);
    endtask

    always @(negedge clk) begin
        if (rst !== 1'b0) reset_model();
        else check_and_step();
    end

    function automatic mshr_pkg::line_t next_fresh_line();
        fresh_line++;
        return 28'(32'h1000 + fresh_line);
    endfunction

    function automatic mshr_pkg::line_t unknown_line();
        return 28'(32'h0F00_0000 + $urandom_range(0, 255));  // outside every miss pool
    endfunction

    function automatic mshr_pkg::op_t random_op();
        return mshr_pkg::op_t'($urandom_range(0, 2));
    endfunction

    task automatic set_inputs(input bit mv, input mshr_pkg::op_t op, input mshr_pkg::line_t line,
                              input bit rv, input mshr_pkg::line_t rline, input bit stall);
        miss_valid <= mv;
        miss_op <= op;
        miss_addr <= {line, 4'($urandom_range(0, 15))};
        l2_resp_valid <= rv;
        l2_resp_addr <= {rline, 4'($urandom_range(0, 15))};
        l2_stall <= stall;
    endtask

    // only entries whose request has gone out
    task automatic pick_requested(output bit ok, output int idx);
        int cand [$];
        for (int i = 0; i < q_length; i++) begin
            if (valid_m[i] && !done_m[i] && requested_m[i]) cand.push_back(i);
        end
        ok = cand.size() > 0;
        idx = 0;
        if (ok) idx = cand[$urandom_range(0, cand.size() - 1)];
    endtask

    task automatic idle(input int n, input bit stall);
        repeat (n) begin
            @(posedge clk);
            set_inputs(1'b0, mshr_pkg::op_load, '0, 1'b0, '0, stall);
        end
    endtask

    task automatic miss(input mshr_pkg::line_t line);
        @(posedge clk);
        set_inputs(1'b1, random_op(), line, 1'b0, '0, 1'b0);
    endtask

    task automatic respond_line(input mshr_pkg::line_t line);
        @(posedge clk);
        set_inputs(1'b0, mshr_pkg::op_load, '0, 1'b1, line, 1'b0);
    endtask

    task automatic random_cycle(input bit stall);
        bit ok, mv, rv;
        int idx;
        mshr_pkg::line_t line, rline;
        @(posedge clk);
        mv = $urandom_range(0, 99) < 55;
        line = 28'(32'h200 + $urandom_range(0, 11));  // small pool, so merges happen
        rv = 1'b0;
        rline = '0;
        if ($urandom_range(0, 99) < 40) begin
            pick_requested(ok, idx);
            if (ok) begin
                rv = 1'b1;
                rline = line_m[idx];
            end else if ($urandom_range(0, 3) == 0) begin
                rv = 1'b1;
                rline = unknown_line();
            end
        end
        set_inputs(mv, random_op(), line, rv, rline, stall);
    endtask

    task automatic drain();
        bit ok;
        int idx;
        @(posedge clk);
        while (count_m != 0 || req_q.size() != 0) begin
            pick_requested(ok, idx);
            set_inputs(1'b0, mshr_pkg::op_load, '0, ok, ok ? line_m[idx] : '0, 1'b0);
            @(posedge clk);
        end
        set_inputs(1'b0, mshr_pkg::op_load, '0, 1'b0, '0, 1'b0);
    endtask

    initial begin
        mshr_pkg::line_t lines [q_length];
        int  n, len;
        bit  stall_on, ok;
        void'($urandom(32'he8c8ade2));
        rst = 1'b1;
        miss_valid = 1'b0;
        miss_op = mshr_pkg::op_load;
        miss_addr = '0;
        l2_stall = 1'b0;
        l2_resp_valid = 1'b0;
        l2_resp_addr = '0;
        fresh_line = 0;
        {n_alloc, n_merge, n_drop, n_fill, n_unknown, n_stalled, n_full_merge} = '0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        idle(3, 1'b0);

        test_name = "primary";
        for (int k = 0; k < 6; k++) begin
            lines[k] = next_fresh_line();
            miss(lines[k]);
        end
        test_name = "secondary";  // entry 5 merges before its request is out
        miss(lines[5]);
        miss(lines[0]);
        miss(lines[2]);
        idle(8, 1'b0);

        test_name = "fill";
        respond_line(unknown_line());
        drain();

        test_name = "full_drop";
        for (int k = 0; k < q_length; k++) begin
            lines[k] = next_fresh_line();
            miss(lines[k]);
        end
        miss(next_fresh_line());
        miss(lines[3]);
        idle(q_length + 2, 1'b0);
        test_name = "out_of_order";
        for (int k = q_length - 1; k >= 1; k--) respond_line(lines[k]);
        idle(3, 1'b0);  // head still open
        respond_line(lines[0]);
        idle(3, 1'b0);
        test_name = "wrap";
        repeat (3) miss(next_fresh_line());
        drain();

        test_name = "stall";
        stall_on = 1'b1;
        n = 0;
        while (n < stall_cycles) begin
            len = stall_on ? $urandom_range(2, 10) : $urandom_range(1, 4);
            repeat (len) random_cycle(stall_on);
            n += len;
            stall_on = !stall_on;
        end

        test_name = "random";
        repeat (random_cycles) random_cycle($urandom_range(0, 99) < 20);
        test_name = "drain";
        drain();
        idle(2, 1'b0);

        ok = n_alloc > 0 && n_merge > 0 && n_drop > 0 && n_fill > 0 && n_unknown > 0
             && n_stalled > 0 && n_full_merge > 0;
        if (ok) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Some miss, fill or stall case was never exercised by the stimulus");
            $display("Finished with errors");
            $fatal(1, "incomplete stimulus");
        end
    end

endmodule

//--- files.f
mshr_pkg.sv
miss_queue.sv
mshr.sv
miss_intake.sv
l2_request_issue.sv
mshr_top.sv
tb_mshr.sv

//--- Makefile
# Verilator simulation of the MSHR block

VERILATOR ?= verilator
TOP       ?= tb_mshr
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run result is taken from the log, not from the exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
